/* source/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 12;
    localparam int IMM_W      = 16;

    // one-hot alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // jal writes the return address here
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  load_op;
        logic                  store_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_8;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
    } inst_ctrl_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  load_op;
        logic                  store_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_8;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [IMM_W-1:0]      imm;
        logic [XLEN-1:0]       rs_value;
        logic [XLEN-1:0]       rt_value;
        logic [XLEN-1:0]       pc;
    } decode_pkt_t;

    // forwarding view of a later stage
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       result;
    } fwd_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        logic            stall;
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_t;

    typedef struct packed {
        logic is_beq;
        logic is_bne;
        logic is_jr;
        logic is_j;
        logic is_jal;
    } branch_kind_t;

endpackage

`default_nettype wire

/* source/inst_decoder.sv */
`default_nettype none

module inst_decoder (
    input  logic [decode_pkg::XLEN-1:0]       inst,
    output decode_pkg::inst_ctrl_t            ctrl,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs,
    output logic [decode_pkg::REG_ADDR_W-1:0] rt,
    output logic                              rs_used,
    output logic                              rt_used,
    output decode_pkg::branch_kind_t          br_kind
);
    import decode_pkg::*;

    logic [5:0]            op;
    logic [5:0]            func;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] sa;
    logic                  special;
    logic                  rr_ok;
    logic                  sh_ok;
    logic is_addu, is_subu, is_slt, is_sltu;
    logic is_and, is_or, is_xor, is_nor;
    logic is_sll, is_srl, is_sra, is_jr;
    logic is_addiu, is_lui, is_lw, is_sw;
    logic is_beq, is_bne, is_j, is_jal;
    logic r_alu;
    logic shift;
    logic imm_dst;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    // register forms need sa clear, shifts need rs clear
    assign special = (op == OP_SPECIAL);
    assign rr_ok   = special && (sa == '0);
    assign sh_ok   = special && (rs == '0);

    assign is_addu  = rr_ok && (func == FN_ADDU);
    assign is_subu  = rr_ok && (func == FN_SUBU);
    assign is_slt   = rr_ok && (func == FN_SLT);
    assign is_sltu  = rr_ok && (func == FN_SLTU);
    assign is_and   = rr_ok && (func == FN_AND);
    assign is_or    = rr_ok && (func == FN_OR);
    assign is_xor   = rr_ok && (func == FN_XOR);
    assign is_nor   = rr_ok && (func == FN_NOR);
    assign is_sll   = sh_ok && (func == FN_SLL);
    assign is_srl   = sh_ok && (func == FN_SRL);
    assign is_sra   = sh_ok && (func == FN_SRA);
    assign is_jr    = rr_ok && (func == FN_JR) && (rt == '0) && (rd == '0);
    assign is_addiu = (op == OP_ADDIU);
    assign is_lui   = (op == OP_LUI) && (rs == '0);
    assign is_lw    = (op == OP_LW);
    assign is_sw    = (op == OP_SW);
    assign is_beq   = (op == OP_BEQ);
    assign is_bne   = (op == OP_BNE);
    assign is_j     = (op == OP_J);
    assign is_jal   = (op == OP_JAL);

    assign r_alu   = is_addu | is_subu | is_slt | is_sltu | is_and | is_or | is_xor | is_nor;
    assign shift   = is_sll | is_srl | is_sra;
    assign imm_dst = is_addiu | is_lui | is_lw;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = is_addu | is_addiu | is_lw | is_sw | is_jal;
        ctrl.alu_op[ALU_SUB]  = is_subu;
        ctrl.alu_op[ALU_SLT]  = is_slt;
        ctrl.alu_op[ALU_SLTU] = is_sltu;
        ctrl.alu_op[ALU_AND]  = is_and;
        ctrl.alu_op[ALU_NOR]  = is_nor;
        ctrl.alu_op[ALU_OR]   = is_or;
        ctrl.alu_op[ALU_XOR]  = is_xor;
        ctrl.alu_op[ALU_SLL]  = is_sll;
        ctrl.alu_op[ALU_SRL]  = is_srl;
        ctrl.alu_op[ALU_SRA]  = is_sra;
        ctrl.alu_op[ALU_LUI]  = is_lui;
        ctrl.load_op     = is_lw;
        ctrl.store_op    = is_sw;
        ctrl.src1_is_sa  = shift;
        ctrl.src1_is_pc  = is_jal;
        ctrl.src2_is_imm = is_addiu | is_lui | is_lw | is_sw;
        ctrl.src2_is_8   = is_jal;
        // unknown encodings fall out with no write
        ctrl.gr_we       = r_alu | shift | imm_dst | is_jal;
        if (is_jal) begin
            ctrl.dest = LINK_REG;
        end else if (imm_dst) begin
            ctrl.dest = rt;
        end else begin
            ctrl.dest = rd;
        end
    end

    assign rs_used = r_alu | is_addiu | is_lw | is_sw | is_beq | is_bne | is_jr;
    assign rt_used = r_alu | shift | is_sw | is_beq | is_bne;

    assign br_kind.is_beq = is_beq;
    assign br_kind.is_bne = is_bne;
    assign br_kind.is_jr  = is_jr;
    assign br_kind.is_j   = is_j;
    assign br_kind.is_jal = is_jal;

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic                              clk,
    input  logic [decode_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [decode_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [decode_pkg::XLEN-1:0]       rdata1,
    output logic [decode_pkg::XLEN-1:0]       rdata2,
    input  decode_pkg::rf_write_t             wr
);
    import decode_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // register 0 never written
    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // same-cycle write not visible here, write-back forwarding covers it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* source/operand_forward.sv */
`default_nettype none

module operand_forward (
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rt,
    input  logic                              rs_used,
    input  logic                              rt_used,
    input  logic [decode_pkg::XLEN-1:0]       rf_rdata1,
    input  logic [decode_pkg::XLEN-1:0]       rf_rdata2,
    input  decode_pkg::fwd_t                  es,
    input  logic                              es_load,
    input  decode_pkg::fwd_t                  ms,
    input  decode_pkg::rf_write_t             ws,
    output logic [decode_pkg::XLEN-1:0]       rs_value,
    output logic [decode_pkg::XLEN-1:0]       rt_value,
    output logic                              blocked
);
    import decode_pkg::*;

    logic rs_es_hit;
    logic rs_ms_hit;
    logic rs_ws_hit;
    logic rt_es_hit;
    logic rt_ms_hit;
    logic rt_ws_hit;

    // r0 never matches, nor does a field the instruction ignores
    function automatic logic hit(
        input logic                  stage_valid,
        input logic [REG_ADDR_W-1:0] stage_dest,
        input logic [REG_ADDR_W-1:0] src,
        input logic                  used
    );
        return stage_valid && used && (stage_dest == src) && (src != '0);
    endfunction

    assign rs_es_hit = hit(es.valid, es.dest, rs, rs_used);
    assign rs_ms_hit = hit(ms.valid, ms.dest, rs, rs_used);
    assign rs_ws_hit = hit(ws.we, ws.waddr, rs, rs_used);
    assign rt_es_hit = hit(es.valid, es.dest, rt, rt_used);
    assign rt_ms_hit = hit(ms.valid, ms.dest, rt, rt_used);
    assign rt_ws_hit = hit(ws.we, ws.waddr, rt, rt_used);

    // youngest stage wins; a load in execute has no data yet
    assign rs_value = (rs_es_hit && !es_load) ? es.result :
                      rs_ms_hit               ? ms.result :
                      rs_ws_hit               ? ws.wdata  :
                                                rf_rdata1;

    assign rt_value = (rt_es_hit && !es_load) ? es.result :
                      rt_ms_hit               ? ms.result :
                      rt_ws_hit               ? ws.wdata  :
                                                rf_rdata2;

    assign blocked = es_load && (rs_es_hit || rt_es_hit);

endmodule

`default_nettype wire

/* source/branch_resolve.sv */
`default_nettype none

module branch_resolve (
    input  logic                         ds_valid,
    input  logic [decode_pkg::XLEN-1:0]  pc,
    input  logic [decode_pkg::IMM_W-1:0] imm,
    input  logic [25:0]                  jidx,
    input  decode_pkg::branch_kind_t     br_kind,
    input  logic [decode_pkg::XLEN-1:0]  rs_value,
    input  logic [decode_pkg::XLEN-1:0]  rt_value,
    input  logic                         blocked,
    output decode_pkg::branch_t          br
);
    import decode_pkg::*;

    logic [XLEN-1:0] slot_pc;
    logic [XLEN-1:0] br_offset;
    logic            rs_eq_rt;
    logic            cond_br;

    // targets are relative to the delay slot
    assign slot_pc   = pc + XLEN'(4);
    assign br_offset = {{(XLEN-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign cond_br   = br_kind.is_beq || br_kind.is_bne;

    assign br.taken = ds_valid && (br_kind.is_beq && rs_eq_rt
                                || br_kind.is_bne && !rs_eq_rt
                                || br_kind.is_j
                                || br_kind.is_jal
                                || br_kind.is_jr);

    assign br.target = cond_br                         ? slot_pc + br_offset :
                       br_kind.is_jr                   ? rs_value :
                       (br_kind.is_j || br_kind.is_jal) ? {slot_pc[XLEN-1:XLEN-4], jidx, 2'b00} :
                                                         '0;

    // fetch must wait while the compare operands are still in flight
    assign br.stall = blocked && ds_valid && (cond_br || br_kind.is_jr);

endmodule

`default_nettype wire

/* source/id_stage.sv */
`default_nettype none

module id_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fs_to_ds_valid,
    input  decode_pkg::fetch_pkt_t  fs_to_ds_bus,
    output logic                    ds_allowin,
    output logic                    ds_to_es_valid,
    output decode_pkg::decode_pkt_t ds_to_es_bus,
    input  logic                    es_allowin,
    output decode_pkg::branch_t     br_bus,
    input  decode_pkg::rf_write_t   ws_to_rf_bus,
    input  decode_pkg::fwd_t        es_fwd_bus,
    input  logic                    es_load,
    input  decode_pkg::fwd_t        ms_fwd_bus
);
    import decode_pkg::*;

    logic                  ds_valid;
    logic                  ds_ready_go;
    fetch_pkt_t            ds_pkt;
    inst_ctrl_t            ctrl;
    branch_kind_t          br_kind;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic                  rs_used;
    logic                  rt_used;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       rs_value;
    logic [XLEN-1:0]       rt_value;
    logic [IMM_W-1:0]      imm;
    logic                  blocked;

    assign ds_ready_go    = !blocked;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pkt <= fs_to_ds_bus;
        end
    end

    assign imm = ds_pkt.inst[IMM_W-1:0];

    inst_decoder u_inst_decoder (
        .inst    (ds_pkt.inst),
        .ctrl    (ctrl),
        .rs      (rs),
        .rt      (rt),
        .rs_used (rs_used),
        .rt_used (rt_used),
        .br_kind (br_kind)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_to_rf_bus)
    );

    operand_forward u_operand_forward (
        .rs        (rs),
        .rt        (rt),
        .rs_used   (rs_used),
        .rt_used   (rt_used),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es        (es_fwd_bus),
        .es_load   (es_load),
        .ms        (ms_fwd_bus),
        .ws        (ws_to_rf_bus),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .blocked   (blocked)
    );

    branch_resolve u_branch_resolve (
        .ds_valid (ds_valid),
        .pc       (ds_pkt.pc),
        .imm      (imm),
        .jidx     (ds_pkt.inst[25:0]),
        .br_kind  (br_kind),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .blocked  (blocked),
        .br       (br_bus)
    );

    assign ds_to_es_bus = '{
        alu_op:      ctrl.alu_op,
        load_op:     ctrl.load_op,
        store_op:    ctrl.store_op,
        src1_is_sa:  ctrl.src1_is_sa,
        src1_is_pc:  ctrl.src1_is_pc,
        src2_is_imm: ctrl.src2_is_imm,
        src2_is_8:   ctrl.src2_is_8,
        gr_we:       ctrl.gr_we,
        dest:        ctrl.dest,
        imm:         imm,
        rs_value:    rs_value,
        rt_value:    rt_value,
        pc:          ds_pkt.pc
    };

endmodule

`default_nettype wire

/* testbench/id_stage_asserts.sv */
`default_nettype none

module id_stage_asserts (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    ds_valid,
    input wire decode_pkg::fetch_pkt_t  ds_pkt,
    input wire logic                    ds_to_es_valid,
    input wire logic                    es_allowin,
    input wire decode_pkg::decode_pkt_t ds_to_es_bus,
    input wire logic                    blocked
);

    // stage comes out of reset empty
    a_reset_empty: assert property (@(posedge clk) reset |=> !ds_to_es_valid)
        else $error("ds_to_es_valid high right after reset");

    // stalled by execute, the offered packet must hold
    a_bus_stable: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |=> $stable(ds_to_es_bus))
        else $error("ds_to_es_bus changed under back-pressure");

    // a load-use stall keeps the instruction in place
    a_stall_holds: assert property (@(posedge clk) disable iff (reset)
        (ds_valid && blocked) |=> (ds_valid && $stable(ds_pkt)))
        else $error("instruction lost or replaced during load-use stall");

endmodule

bind id_stage id_stage_asserts u_id_stage_asserts (
    .clk            (clk),
    .reset          (reset),
    .ds_valid       (ds_valid),
    .ds_pkt         (ds_pkt),
    .ds_to_es_valid (ds_to_es_valid),
    .es_allowin     (es_allowin),
    .ds_to_es_bus   (ds_to_es_bus),
    .blocked        (blocked)
);

`default_nettype wire

/* testbench/id_stage_tb.sv */
`default_nettype none

module id_stage_tb;
    import decode_pkg::*;

    localparam int REC_W = 13;
    localparam int MAX_REC = 48;

    logic          clk = 1'b0;
    logic          reset;
    logic          fs_to_ds_valid;
    fetch_pkt_t    fs_to_ds_bus;
    logic          ds_allowin;
    logic          ds_to_es_valid;
    decode_pkt_t   ds_to_es_bus;
    logic          es_allowin = 1'b1;
    branch_t       br_bus;
    rf_write_t     ws_to_rf_bus;
    fwd_t          es_fwd_bus;
    logic          es_load;
    fwd_t          ms_fwd_bus;

    logic [31:0] pat [MAX_REC*REC_W];
    int          errors = 0;
    int          n_rec = 0;
    int          limit = 0;

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .br_bus         (br_bus),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .es_fwd_bus     (es_fwd_bus),
        .es_load        (es_load),
        .ms_fwd_bus     (ms_fwd_bus)
    );

    always #5 clk = !clk;

    // execute accepts about three cycles in four
    initial begin
        void'($urandom(32'h56e2cc58));
        forever begin
            @(posedge clk);
            if (reset) begin
                es_allowin <= 1'b1;
            end else begin
                es_allowin <= ($urandom % 4) != 0;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic write_reg(input int base);
        @(posedge clk);
        ws_to_rf_bus <= {1'b1, pat[base+1][4:0], pat[base+2]};
        @(posedge clk);
        ws_to_rf_bus <= '0;
    endtask

    task automatic run_inst(input int base);
        logic [31:0] ctl;
        logic [31:0] esctl;
        ctl = pat[base+9];
        esctl = pat[base+3];
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds_bus <= {pat[base+1], pat[base+2]};
        es_fwd_bus <= {esctl[5], esctl[4:0], pat[base+4]};
        es_load <= esctl[8];
        ms_fwd_bus <= {pat[base+5][5], pat[base+5][4:0], pat[base+6]};
        ws_to_rf_bus <= {pat[base+7][5], pat[base+7][4:0], pat[base+8]};
        do @(negedge clk); while (!ds_allowin);
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        if (ctl[7]) begin
            @(negedge clk);
            check("ds_to_es_valid", {31'd0, ds_to_es_valid}, 32'd0);
            check("ds_allowin", {31'd0, ds_allowin}, 32'd0);
            check("br_bus.stall", {31'd0, br_bus.stall}, {31'd0, ctl[8]});
            // the load moves on to memory and its data becomes available
            @(posedge clk);
            es_fwd_bus <= '0;
            es_load <= 1'b0;
            ms_fwd_bus <= {1'b1, esctl[4:0], pat[base+4]};
        end
        forever begin
            @(negedge clk);
            if (ds_to_es_valid && es_allowin) begin
                break;
            end
            if (!es_allowin) begin
                check("ds_allowin", {31'd0, ds_allowin}, 32'd0);
            end
        end
        check("pc", ds_to_es_bus.pc, pat[base+2]);
        check("dest", {27'd0, ds_to_es_bus.dest}, {27'd0, ctl[4:0]});
        check("gr_we", {31'd0, ds_to_es_bus.gr_we}, {31'd0, ctl[5]});
        check("alu_op", {20'd0, ds_to_es_bus.alu_op}, {20'd0, ctl[20:9]});
        check("rs_value", ds_to_es_bus.rs_value, pat[base+10]);
        check("rt_value", ds_to_es_bus.rt_value, pat[base+11]);
        check("br_bus.taken", {31'd0, br_bus.taken}, {31'd0, ctl[6]});
        // operands are all available once the instruction leaves
        check("br_bus.stall", {31'd0, br_bus.stall}, 32'd0);
        if (ctl[6]) begin
            check("br_bus.target", br_bus.target, pat[base+12]);
        end
        @(posedge clk);
        es_fwd_bus <= '0;
        es_load <= 1'b0;
        ms_fwd_bus <= '0;
        ws_to_rf_bus <= '0;
        // the stage must empty after a single transfer
        @(negedge clk);
        check("ds_to_es_valid", {31'd0, ds_to_es_valid}, 32'd0);
    endtask

    initial begin
        $readmemh("testbench/id_stage_patterns.hex", pat);
        while (n_rec < MAX_REC && (pat[n_rec*REC_W] == 32'h0 || pat[n_rec*REC_W] == 32'h1)) begin
            n_rec++;
        end
        limit = 10 + n_rec * 30;
        reset <= 1'b1;
        fs_to_ds_valid <= 1'b0;
        fs_to_ds_bus <= '0;
        ws_to_rf_bus <= '0;
        es_fwd_bus <= '0;
        es_load <= 1'b0;
        ms_fwd_bus <= '0;
        if (n_rec == 0) begin
            errors++;
            $display("no pattern records found in testbench/id_stage_patterns.hex");
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("ds_allowin", {31'd0, ds_allowin}, 32'd1);
        check("ds_to_es_valid", {31'd0, ds_to_es_valid}, 32'd0);
        check("br_bus.taken", {31'd0, br_bus.taken}, 32'd0);
        check("br_bus.stall", {31'd0, br_bus.stall}, 32'd0);
        for (int r = 0; r < n_rec; r++) begin
            if (pat[r*REC_W] == 32'h0) begin
                write_reg(r * REC_W);
            end else begin
                run_inst(r * REC_W);
            end
        end
        $display("records: %0d errors: %0d", n_rec, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (limit != 0);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, DUT stopped responding", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/id_stage_patterns.hex */
// kind(0 regwrite: addr data, 1 inst) inst pc es_ctl es_res ms_ctl ms_res ws_ctl ws_data
// exp_ctl(alu_op<<9|br_stall<<8|stalled<<7|taken<<6|gr_we<<5|dest) exp_rs exp_rt exp_target
0 01 11111111 0 0 0 0 0 0 0 0 0 0
0 02 22222222 0 0 0 0 0 0 0 0 0 0
0 03 33333333 0 0 0 0 0 0 0 0 0 0
0 00 deadbeef 0 0 0 0 0 0 0 0 0 0
1 00222021 00400000 0 0 0 0 0 0 224 11111111 22222222 0
1 00222823 00400004 0 0 0 0 0 0 425 11111111 22222222 0
1 0022302a 00400008 0 0 0 0 0 0 826 11111111 22222222 0
1 0022382b 0040000c 0 0 0 0 0 0 1027 11111111 22222222 0
1 00224024 00400010 0 0 0 0 0 0 2028 11111111 22222222 0
1 00224825 00400014 0 0 0 0 0 0 8029 11111111 22222222 0
1 00225026 00400018 0 0 0 0 0 0 1002a 11111111 22222222 0
1 00225827 0040001c 0 0 0 0 0 0 402b 11111111 22222222 0
1 00026100 00400020 0 0 0 0 0 0 2002c 00000000 22222222 0
1 00036842 00400024 0 0 0 0 0 0 4002d 00000000 33333333 0
1 00037083 00400028 0 0 0 0 0 0 8002e 00000000 33333333 0
1 24220010 00400030 22 aaaaaaaa 0 0 0 0 222 11111111 22222222 0
1 3c031234 00400034 0 0 0 0 0 0 100023 00000000 33333333 0
1 8c410008 00400038 0 0 0 0 0 0 221 22222222 11111111 0
1 ac230004 0040003c 0 0 0 0 0 0 200 11111111 33333333 0
1 fc000000 00400040 0 0 0 0 0 0 0 00000000 00000000 0
1 00012021 00400044 20 55555555 0 0 20 deadbeef 224 00000000 11111111 0
1 00222021 00400048 21 aaaaaaaa 21 bbbbbbbb 21 cccccccc 224 aaaaaaaa 22222222 0
1 00222021 0040004c 01 aaaaaaaa 21 bbbbbbbb 21 dddddddd 224 bbbbbbbb 22222222 0
1 00222021 00400050 01 aaaaaaaa 01 bbbbbbbb 21 eeeeeeee 224 eeeeeeee 22222222 0
1 00222021 00400054 0 0 0 0 0 0 224 eeeeeeee 22222222 0
1 00222021 00400058 122 77777777 0 0 0 0 2a4 eeeeeeee 77777777 0
1 10220003 00001000 121 22222222 0 0 0 0 1c0 22222222 22222222 00001010
1 1422fffe 00002000 0 0 0 0 0 0 5f eeeeeeee 22222222 00001ffc
1 10220003 00003000 0 0 0 0 0 0 0 eeeeeeee 22222222 0
1 14420001 00003004 0 0 0 0 0 0 0 22222222 22222222 0
1 08010040 10000ffc 0 0 0 0 0 0 40 00000000 eeeeeeee 10040100
1 0c010040 00400000 0 0 0 0 0 0 27f 00000000 eeeeeeee 00040100
1 00400008 00005000 0 0 0 0 0 0 40 22222222 00000000 22222222
1 00600008 00005004 123 00008000 0 0 0 0 1c0 00008000 00000000 00008000
f 0 0 0 0 0 0 0 0 0 0 0 0

/* all.f */
source/decode_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_forward.sv
source/branch_resolve.sv
source/id_stage.sv
testbench/id_stage_asserts.sv
testbench/id_stage_tb.sv

/* Makefile */
SIM = obj_dir/Vid_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f all.f --top-module id_stage_tb

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
